// File: common/commit_params.svh
/*
 * Commit subsystem parameters
 * Data and instruction widths, ROB depth and register index width
 */

`ifndef COMMIT_PARAMS_SVH
`define COMMIT_PARAMS_SVH

// Datapath width
`define COMMIT_XLEN 32

// Instruction width in bits, link offset is ILEN/8
`define COMMIT_ILEN 32

// ROB entries, power of two
`define COMMIT_ROB_DEPTH 8

// Integer register index width
`define COMMIT_REG_IDX_LEN 5

`endif

// File: common/rob_pkg.sv
/*
 * ROB types
 * Slot index, RV32 opcodes and the finished-instruction entry
 */

`include "commit_params.svh"

package rob_pkg;

    // Slot index, doubles as the ROB tag
    typedef logic [$clog2(`COMMIT_ROB_DEPTH)-1:0] rob_idx_t;

    // Major opcodes seen at commit
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // One finished instruction
    typedef struct packed {
        opcode_e                        opcode;
        logic [`COMMIT_REG_IDX_LEN-1:0] rd_idx;
        logic [`COMMIT_XLEN-1:0]        instr_pc;
        // Result, or computed target for jumps and branches
        logic [`COMMIT_XLEN-1:0]        res_value;
        logic                           taken;
        logic                           mispredicted;
        logic                           except_raised;
        logic [4:0]                     except_code;
    } rob_entry_t;

endpackage

// File: common/commit_pkg.sv
/*
 * Commit stage types
 * Commit classes, control unit states and the front-end resolution
 */

`include "commit_params.svh"

package commit_pkg;

    // Class of the head instruction
    typedef enum logic [2:0] {
        COMM_INT,
        COMM_STORE,
        COMM_JUMP,
        COMM_BRANCH,
        COMM_EXCEPT
    } comm_type_e;

    // Commit CU states
    typedef enum logic [2:0] {
        IDLE,
        COMMIT_INT,
        COMMIT_STORE,
        COMMIT_JUMP,
        COMMIT_BRANCH,
        MISPREDICT,
        EXCEPTION,
        RESUME
    } commit_state_e;

    // Jump/branch outcome to the front end
    typedef struct packed {
        logic [`COMMIT_XLEN-1:0] pc;
        logic [`COMMIT_XLEN-1:0] target;
        logic                    taken;
        logic                    mispredict;
    } resolution_t;

endpackage

// File: rtl/spill_cell.sv
/*
 * Spill cell
 * Two-slot valid/ready slice with registered ready and flush
 */

`timescale 1ns/1ns

module spill_cell #(
    parameter type DATA_T = logic [7:0]
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    // Upstream
    input  logic  valid_i,
    output logic  ready_o,
    input  DATA_T data_i,
    // Downstream
    output logic  valid_o,
    input  logic  ready_i,
    output DATA_T data_o
);

    logic  main_valid_q, spare_valid_q;
    DATA_T main_data_q, spare_data_q;
    logic  accept_in, main_free;

    // Ready only from the spare slot state
    assign ready_o   = !spare_valid_q;
    assign accept_in = valid_i && ready_o;
    // Main slot drains or is empty
    assign main_free = !main_valid_q || ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_valid_q  <= 1'b0;
            spare_valid_q <= 1'b0;
        end else if (flush_i) begin
            main_valid_q  <= 1'b0;
            spare_valid_q <= 1'b0;
        end else if (main_free) begin
            // Spare has priority, it holds the older item
            main_valid_q  <= spare_valid_q || accept_in;
            spare_valid_q <= 1'b0;
        end else if (accept_in) begin
            // Downstream stalled, catch the item
            spare_valid_q <= 1'b1;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (main_free) begin
            main_data_q <= spare_valid_q ? spare_data_q : data_i;
        end else if (accept_in) begin
            spare_data_q <= data_i;
        end
    end

    assign valid_o = main_valid_q;
    assign data_o  = main_data_q;

    // Nothing survives a flush
    a_flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !valid_o);

endmodule

// File: rtl/rob_fifo.sv
/*
 * Reorder buffer
 * Circular FIFO of finished entries whose slot number is the ROB index
 */

`timescale 1ns/1ns

`include "commit_params.svh"

module rob_fifo (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    // Insertion
    input  logic                ins_valid_i,
    input  rob_pkg::rob_entry_t ins_entry_i,
    output logic                ins_ready_o,
    // Head
    output logic                head_valid_o,
    output rob_pkg::rob_entry_t head_entry_o,
    output rob_pkg::rob_idx_t   head_idx_o,
    input  logic                head_ready_i
);

    localparam int DEPTH = `COMMIT_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    rob_pkg::rob_entry_t mem_q [DEPTH];
    rob_pkg::rob_idx_t   head_q, tail_q;
    logic [CNT_W-1:0]    count_q;
    logic                full, push, pop;

    // --------------------
    // Handshakes
    // --------------------
    assign full         = (count_q == CNT_W'(DEPTH));
    assign ins_ready_o  = !full && !flush_i;
    assign head_valid_o = (count_q != '0);
    assign push         = ins_valid_i && ins_ready_o;
    assign pop          = head_valid_o && head_ready_i;

    // --------------------
    // Pointers and count
    // --------------------
    // Pointers wrap naturally on a power-of-two depth
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[tail_q] <= ins_entry_i;
        end
    end

    assign head_entry_o = mem_q[head_q];
    assign head_idx_o   = head_q;

    // Overflow and underflow guards
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        full && !pop |=> count_q == CNT_W'(DEPTH) || $past(flush_i));
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        head_ready_i && !head_valid_o |=> head_q == $past(head_q) || $past(flush_i));

endmodule

// File: commit_stage/commit_decoder.sv
/*
 * Commit decoder
 * Classifies the head instruction for the commit CU
 */

`timescale 1ns/1ns

module commit_decoder (
    input  rob_pkg::opcode_e       opcode_i,
    input  logic                   except_raised_i,
    output commit_pkg::comm_type_e comm_type_o
);

    always_comb begin
        // Exceptions override the opcode class
        if (except_raised_i) begin
            comm_type_o = commit_pkg::COMM_EXCEPT;
        end else begin
            case (opcode_i)
                rob_pkg::STORE: begin
                    comm_type_o = commit_pkg::COMM_STORE;
                end
                rob_pkg::JAL,
                rob_pkg::JALR: begin
                    comm_type_o = commit_pkg::COMM_JUMP;
                end
                rob_pkg::BRANCH: begin
                    comm_type_o = commit_pkg::COMM_BRANCH;
                end
                // OP, OP_IMM, LOAD write rd only
                default: begin
                    comm_type_o = commit_pkg::COMM_INT;
                end
            endcase
        end
    end

endmodule

// File: commit_stage/commit_cu.sv
/*
 * Commit control unit
 * Moore FSM sequencing retirement, store waits, flush and resume
 */

`timescale 1ns/1ns

module commit_cu (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Spill cell side
    input  logic                   valid_i,
    output logic                   ready_o,
    // Head classification
    input  commit_pkg::comm_type_e comm_type_i,
    input  logic                   store_comm_i,
    input  logic                   mispredict_i,
    input  logic                   rd_nonzero_i,
    // Commit actions
    output logic                   rf_we_o,
    output logic                   is_jump_o,
    output logic                   sb_pop_store_o,
    output logic                   fe_res_valid_o,
    output logic                   except_raised_o,
    output logic                   flush_o,
    output logic                   resume_o
);

    commit_pkg::commit_state_e state_q, state_d;
    logic accept;
    logic rd_nz_q, jump_q;

    // --------------------
    // Acceptance
    // --------------------
    always_comb begin
        case (state_q)
            commit_pkg::IDLE,
            commit_pkg::COMMIT_INT,
            commit_pkg::COMMIT_STORE,
            commit_pkg::COMMIT_JUMP,
            commit_pkg::COMMIT_BRANCH: begin
                // Stores wait for the store buffer head
                ready_o = !(comm_type_i == commit_pkg::COMM_STORE && !store_comm_i);
            end
            default: begin
                ready_o = 1'b0;
            end
        endcase
    end

    assign accept = valid_i && ready_o;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            commit_pkg::MISPREDICT,
            commit_pkg::EXCEPTION: begin
                state_d = commit_pkg::RESUME;
            end
            commit_pkg::RESUME: begin
                state_d = commit_pkg::IDLE;
            end
            default: begin
                if (!accept) begin
                    state_d = commit_pkg::IDLE;
                end else begin
                    case (comm_type_i)
                        commit_pkg::COMM_STORE: state_d = commit_pkg::COMMIT_STORE;
                        commit_pkg::COMM_JUMP: begin
                            state_d = mispredict_i ? commit_pkg::MISPREDICT
                                                   : commit_pkg::COMMIT_JUMP;
                        end
                        commit_pkg::COMM_BRANCH: begin
                            state_d = mispredict_i ? commit_pkg::MISPREDICT
                                                   : commit_pkg::COMMIT_BRANCH;
                        end
                        commit_pkg::COMM_EXCEPT: state_d = commit_pkg::EXCEPTION;
                        default:                 state_d = commit_pkg::COMMIT_INT;
                    endcase
                end
            end
        endcase
    end

    // State and per-entry flags, captured on acceptance
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= commit_pkg::IDLE;
            rd_nz_q <= 1'b0;
            jump_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                rd_nz_q <= rd_nonzero_i;
                jump_q  <= (comm_type_i == commit_pkg::COMM_JUMP);
            end
        end
    end

    // --------------------
    // Moore outputs
    // --------------------
    // Mispredicted jumps still write the link register
    assign is_jump_o = (state_q == commit_pkg::COMMIT_JUMP) ||
                       (state_q == commit_pkg::MISPREDICT && jump_q);
    // x0 writes dropped
    assign rf_we_o = rd_nz_q && (is_jump_o || state_q == commit_pkg::COMMIT_INT);
    assign sb_pop_store_o  = (state_q == commit_pkg::COMMIT_STORE);
    assign fe_res_valid_o  = (state_q == commit_pkg::COMMIT_JUMP) ||
                             (state_q == commit_pkg::COMMIT_BRANCH) ||
                             (state_q == commit_pkg::MISPREDICT);
    assign except_raised_o = (state_q == commit_pkg::EXCEPTION);
    assign flush_o         = (state_q == commit_pkg::MISPREDICT) ||
                             (state_q == commit_pkg::EXCEPTION);
    assign resume_o        = (state_q == commit_pkg::RESUME);

    // Front end restarts right after every flush
    a_flush_resume: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_o |=> resume_o);

endmodule

// File: commit_stage/commit_stage.sv
/*
 * Commit stage
 * Spill cell, commit decoder and CU retiring ROB head entries in order
 */

`timescale 1ns/1ns

`include "commit_params.svh"

module commit_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    // ROB head
    input  logic                           rob_valid_i,
    output logic                           rob_ready_o,
    input  rob_pkg::rob_entry_t            rob_head_entry_i,
    input  rob_pkg::rob_idx_t              rob_head_idx_i,
    // Store buffer
    input  logic                           sb_head_completed_i,
    input  rob_pkg::rob_idx_t              sb_head_rob_idx_i,
    output logic                           sb_pop_store_o,
    // Register file
    output logic                           rf_we_o,
    output logic [`COMMIT_REG_IDX_LEN-1:0] rd_idx_o,
    output logic [`COMMIT_XLEN-1:0]        rd_value_o,
    // Front end
    output logic                           fe_res_valid_o,
    output commit_pkg::resolution_t        fe_res_o,
    output logic                           fe_except_raised_o,
    output logic [`COMMIT_XLEN-1:0]        fe_except_pc_o,
    // Pipeline control
    output logic                           flush_o,
    output logic                           resume_o
);

    // Entry with its ROB tag
    typedef struct packed {
        rob_pkg::rob_entry_t data;
        rob_pkg::rob_idx_t   rob_idx;
    } inreg_data_t;

    inreg_data_t            inreg_in, inreg_out;
    logic                   inreg_valid, cu_ready;
    commit_pkg::comm_type_e comm_type;
    logic                   store_comm, rd_nonzero, is_jump;
    rob_pkg::rob_entry_t    comm_reg_q;
    logic [`COMMIT_XLEN-1:0] link_addr;

    // --------------------
    // Input spill cell
    // --------------------
    assign inreg_in.data    = rob_head_entry_i;
    assign inreg_in.rob_idx = rob_head_idx_i;

    spill_cell #(.DATA_T(inreg_data_t)) u_inreg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_o),
        .valid_i (rob_valid_i),
        .ready_o (rob_ready_o),
        .data_i  (inreg_in),
        .valid_o (inreg_valid),
        .ready_i (cu_ready),
        .data_o  (inreg_out)
    );

    // --------------------
    // Decode and control
    // --------------------
    commit_decoder u_decoder (
        .opcode_i        (inreg_out.data.opcode),
        .except_raised_i (inreg_out.data.except_raised),
        .comm_type_o     (comm_type)
    );

    // Store may retire once the SB head is this entry and done
    assign store_comm = sb_head_completed_i && (sb_head_rob_idx_i == inreg_out.rob_idx);
    assign rd_nonzero = (inreg_out.data.rd_idx != '0);

    commit_cu u_cu (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .valid_i         (inreg_valid),
        .ready_o         (cu_ready),
        .comm_type_i     (comm_type),
        .store_comm_i    (store_comm),
        .mispredict_i    (inreg_out.data.mispredicted),
        .rd_nonzero_i    (rd_nonzero),
        .rf_we_o         (rf_we_o),
        .is_jump_o       (is_jump),
        .sb_pop_store_o  (sb_pop_store_o),
        .fe_res_valid_o  (fe_res_valid_o),
        .except_raised_o (fe_except_raised_o),
        .flush_o         (flush_o),
        .resume_o        (resume_o)
    );

    // Committing instruction, lines up with the CU Moore outputs
    always_ff @(posedge clk_i) begin
        if (inreg_valid && cu_ready) begin
            comm_reg_q <= inreg_out.data;
        end
    end

    // --------------------
    // Output datapath
    // --------------------
    // Return address for jumps
    assign link_addr  = comm_reg_q.instr_pc + (`COMMIT_ILEN >> 3);
    assign rd_idx_o   = comm_reg_q.rd_idx;
    assign rd_value_o = is_jump ? link_addr : comm_reg_q.res_value;

    assign fe_res_o.pc         = comm_reg_q.instr_pc;
    assign fe_res_o.target     = {comm_reg_q.res_value[`COMMIT_XLEN-1:1], 1'b0};
    assign fe_res_o.taken      = is_jump || comm_reg_q.taken;
    assign fe_res_o.mispredict = comm_reg_q.mispredicted;

    assign fe_except_pc_o = comm_reg_q.instr_pc;

endmodule

// File: rtl/commit_top.sv
/*
 * Commit subsystem top
 * ROB feeding the in-order commit stage
 */

`timescale 1ns/1ns

`include "commit_params.svh"

module commit_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    // Finished instructions
    input  logic                           ins_valid_i,
    input  rob_pkg::rob_entry_t            ins_entry_i,
    output logic                           ins_ready_o,
    // Store buffer
    input  logic                           sb_head_completed_i,
    input  rob_pkg::rob_idx_t              sb_head_rob_idx_i,
    output logic                           sb_pop_store_o,
    // Register file
    output logic                           rf_we_o,
    output logic [`COMMIT_REG_IDX_LEN-1:0] rd_idx_o,
    output logic [`COMMIT_XLEN-1:0]        rd_value_o,
    // Front end
    output logic                           fe_res_valid_o,
    output commit_pkg::resolution_t        fe_res_o,
    output logic                           fe_except_raised_o,
    output logic [`COMMIT_XLEN-1:0]        fe_except_pc_o,
    // Control
    output logic                           flush_o,
    output logic                           resume_o
);

    logic                rob_valid, rob_ready;
    rob_pkg::rob_entry_t rob_head_entry;
    rob_pkg::rob_idx_t   rob_head_idx;

    // Flush from commit also empties the ROB
    rob_fifo u_rob (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_o),
        .ins_valid_i  (ins_valid_i),
        .ins_entry_i  (ins_entry_i),
        .ins_ready_o  (ins_ready_o),
        .head_valid_o (rob_valid),
        .head_entry_o (rob_head_entry),
        .head_idx_o   (rob_head_idx),
        .head_ready_i (rob_ready)
    );

    commit_stage u_commit (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .rob_valid_i         (rob_valid),
        .rob_ready_o         (rob_ready),
        .rob_head_entry_i    (rob_head_entry),
        .rob_head_idx_i      (rob_head_idx),
        .sb_head_completed_i (sb_head_completed_i),
        .sb_head_rob_idx_i   (sb_head_rob_idx_i),
        .sb_pop_store_o      (sb_pop_store_o),
        .rf_we_o             (rf_we_o),
        .rd_idx_o            (rd_idx_o),
        .rd_value_o          (rd_value_o),
        .fe_res_valid_o      (fe_res_valid_o),
        .fe_res_o            (fe_res_o),
        .fe_except_raised_o  (fe_except_raised_o),
        .fe_except_pc_o      (fe_except_pc_o),
        .flush_o             (flush_o),
        .resume_o            (resume_o)
    );

endmodule

// File: dv/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * Free-running clock, active-low reset held for a fixed number of cycles
 */

`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release just after a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: dv/tb_commit.sv
/*
 * Commit subsystem testbench
 * Random ROB streams, store buffer model, reference model and event checker
 */

`timescale 1ns/1ns

`include "commit_params.svh"

module tb_commit;

    localparam int TIMEOUT = 300;

    typedef enum logic [2:0] {EV_WRITE, EV_POP, EV_RES, EV_EXC, EV_FLUSH} ev_kind_e;

    // One commit event as observed or expected
    typedef struct packed {
        ev_kind_e                kind;
        logic [`COMMIT_XLEN-1:0] a;
        logic [`COMMIT_XLEN-1:0] b;
        logic [1:0]              flags;
    } event_t;

    logic                           clk_i, rst_n_i;
    logic                           ins_valid_i, ins_ready_o;
    rob_pkg::rob_entry_t            ins_entry_i;
    logic                           sb_head_completed_i, sb_pop_store_o;
    rob_pkg::rob_idx_t              sb_head_rob_idx_i;
    logic                           rf_we_o;
    logic [`COMMIT_REG_IDX_LEN-1:0] rd_idx_o;
    logic [`COMMIT_XLEN-1:0]        rd_value_o, fe_except_pc_o;
    logic                           fe_res_valid_o, fe_except_raised_o;
    commit_pkg::resolution_t        fe_res_o;
    logic                           flush_o, resume_o;

    integer                  seed = 28675;
    int                      err_count = 0;
    int                      test_base = 0;
    logic [`COMMIT_XLEN-1:0] next_pc = 32'h0000_1000;
    rob_pkg::rob_entry_t     stim_q[$], ins_q[$];
    event_t                  exp_q[$], obs_q[$];
    // Store buffer model state
    rob_pkg::rob_idx_t       tail_idx = '0;
    rob_pkg::rob_idx_t       sb_q[$];
    int                      sb_wait = 2;
    int                      sb_base = 2;
    logic                    sb_shown = 1'b0;
    logic                    flush_prev = 1'b0;
    logic                    ready_low_seen = 1'b0;

    tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

    commit_top i_dut (.*);

    // --------------------
    // Helpers
    // --------------------
    function automatic event_t make_event(ev_kind_e kind, logic [`COMMIT_XLEN-1:0] a,
                                          logic [`COMMIT_XLEN-1:0] b, logic [1:0] flags);
        return '{kind, a, b, flags};
    endfunction

    function automatic rob_pkg::rob_entry_t new_entry(rob_pkg::opcode_e op);
        rob_pkg::rob_entry_t e;
        e           = '0;
        e.opcode    = op;
        e.rd_idx    = 5'($random(seed));
        e.instr_pc  = next_pc;
        e.res_value = $random(seed);
        e.taken     = 1'($random(seed));
        // x0 shows up often enough to matter
        if (($random(seed) & 7) == 0) begin
            e.rd_idx = '0;
        end
        next_pc = next_pc + 4;
        return e;
    endfunction

    function automatic rob_pkg::opcode_e int_opcode();
        case ($unsigned($random(seed)) % 3)
            0:       return rob_pkg::OP;
            1:       return rob_pkg::OP_IMM;
            default: return rob_pkg::LOAD;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic abort_run(input string msg);
        $display("Timeout, %s", msg);
        $display("test failed");
        $finish;
    endtask

    // --------------------
    // Reference model
    // --------------------
    // Expected events of ins_q in program order up to the first flush
    function automatic void build_expected();
        rob_pkg::rob_entry_t     e;
        logic [`COMMIT_XLEN-1:0] target;
        for (int i = 0; i < ins_q.size(); i++) begin
            e      = ins_q[i];
            target = {e.res_value[`COMMIT_XLEN-1:1], 1'b0};
            if (e.except_raised) begin
                exp_q.push_back(make_event(EV_EXC, e.instr_pc, '0, 2'b00));
                exp_q.push_back(make_event(EV_FLUSH, '0, '0, 2'b00));
                break;
            end
            case (e.opcode)
                rob_pkg::STORE: exp_q.push_back(make_event(EV_POP, '0, '0, 2'b00));
                rob_pkg::JAL,
                rob_pkg::JALR: begin
                    if (e.rd_idx != '0) begin
                        exp_q.push_back(make_event(EV_WRITE, e.rd_idx, e.instr_pc + 4, 2'b00));
                    end
                    exp_q.push_back(make_event(EV_RES, e.instr_pc, target,
                                               {1'b1, e.mispredicted}));
                end
                rob_pkg::BRANCH: begin
                    exp_q.push_back(make_event(EV_RES, e.instr_pc, target,
                                               {e.taken, e.mispredicted}));
                end
                default: begin
                    if (e.rd_idx != '0) begin
                        exp_q.push_back(make_event(EV_WRITE, e.rd_idx, e.res_value, 2'b00));
                    end
                end
            endcase
            if (e.mispredicted &&
                (e.opcode inside {rob_pkg::JAL, rob_pkg::JALR, rob_pkg::BRANCH})) begin
                exp_q.push_back(make_event(EV_FLUSH, '0, '0, 2'b00));
                break;
            end
        end
        ins_q.delete();
    endfunction

    // --------------------
    // Monitor and store buffer model
    // --------------------
    // Outputs sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (rf_we_o) begin
                obs_q.push_back(make_event(EV_WRITE, rd_idx_o, rd_value_o, 2'b00));
            end
            if (sb_pop_store_o) begin
                obs_q.push_back(make_event(EV_POP, '0, '0, 2'b00));
                if (!sb_shown) begin
                    report_error("store popped before the store buffer showed it done");
                end
                if (sb_q.size() > 0) begin
                    void'(sb_q.pop_front());
                end
                sb_shown = 1'b0;
                sb_wait  = sb_base + int'($unsigned($random(seed)) % 4);
            end
            if (fe_res_valid_o) begin
                obs_q.push_back(make_event(EV_RES, fe_res_o.pc, fe_res_o.target,
                                           {fe_res_o.taken, fe_res_o.mispredict}));
            end
            if (fe_except_raised_o) begin
                obs_q.push_back(make_event(EV_EXC, fe_except_pc_o, '0, 2'b00));
            end
            if (flush_o) begin
                obs_q.push_back(make_event(EV_FLUSH, '0, '0, 2'b00));
            end
            if (flush_prev && !resume_o) begin
                report_error("no resume pulse after flush");
            end
            flush_prev = flush_o;
            if (!ins_ready_o) begin
                ready_low_seen = 1'b1;
            end
            // Mirror of ROB slot numbering that a flush resets
            if (flush_o) begin
                tail_idx = '0;
                sb_q.delete();
                sb_shown = 1'b0;
                sb_wait  = sb_base;
            end else if (ins_valid_i && ins_ready_o) begin
                if (ins_entry_i.opcode == rob_pkg::STORE && !ins_entry_i.except_raised) begin
                    sb_q.push_back(tail_idx);
                end
                tail_idx = tail_idx + 1'b1;
            end
        end
    end

    // Head store completes after its delay
    always @(posedge clk_i) begin
        #1;
        if (sb_q.size() > 0 && sb_wait == 0) begin
            sb_head_completed_i = 1'b1;
            sb_head_rob_idx_i   = sb_q[0];
            sb_shown            = 1'b1;
        end else begin
            sb_head_completed_i = 1'b0;
            if (sb_q.size() > 0) begin
                sb_wait--;
            end
        end
    end

    // Compares observed against expected events in order
    always @(posedge clk_i) begin : compare_events
        event_t got, want;
        while (obs_q.size() > 0 && exp_q.size() > 0) begin
            got  = obs_q.pop_front();
            want = exp_q.pop_front();
            if (got !== want) begin
                report_error($sformatf("got %s a=%h b=%h f=%b, expected %s a=%h b=%h f=%b",
                    got.kind.name(), got.a, got.b, got.flags,
                    want.kind.name(), want.a, want.b, want.flags));
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    // Inserts stim_q in order and stops at a flush
    task automatic drive_batch();
        rob_pkg::rob_entry_t e;
        int                  wait_cycles;
        logic                stop;
        stop = 1'b0;
        while (stim_q.size() > 0 && !stop) begin
            e = stim_q.pop_front();
            @(posedge clk_i);
            #1;
            ins_valid_i = 1'b1;
            ins_entry_i = e;
            wait_cycles = 0;
            @(negedge clk_i);
            while (!ins_ready_o && !flush_o) begin
                if (wait_cycles == TIMEOUT) abort_run("the ROB never accepted an entry");
                wait_cycles++;
                @(negedge clk_i);
            end
            if (flush_o) begin
                stop = 1'b1;
            end else begin
                ins_q.push_back(e);
            end
        end
        @(posedge clk_i);
        #1;
        ins_valid_i = 1'b0;
        stim_q.delete();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 || flush_o || resume_o) begin
            if (n == TIMEOUT) abort_run("expected commits did not arrive");
            n++;
            @(negedge clk_i);
        end
        // Monitor has logged this cycle by the next edge
        @(posedge clk_i);
        #1;
        if (obs_q.size() > 0) begin
            report_error("unexpected commit events");
            obs_q.delete();
        end
    endtask

    task automatic close_test(input string name);
        wait_drain();
        if (err_count == test_base) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - test_base);
        end
        test_base = err_count;
    endtask

    initial begin : main
        rob_pkg::rob_entry_t e;
        int                  n;
        ins_valid_i         = 1'b0;
        ins_entry_i         = '0;
        sb_head_completed_i = 1'b0;
        sb_head_rob_idx_i   = '0;

        n = 0;
        while (!rst_n_i) begin
            if (n == TIMEOUT) abort_run("reset was never released");
            n++;
            @(negedge clk_i);
        end
        @(negedge clk_i);
        if ({rf_we_o, sb_pop_store_o, fe_res_valid_o, flush_o, resume_o} !== 5'b0 ||
            ins_ready_o !== 1'b1) begin
            report_error("outputs not idle after reset");
        end
        close_test("test 1 reset state");

        // Slow store at the head backs up the ROB
        sb_base = 20;
        sb_wait = 20;
        ready_low_seen = 1'b0;
        stim_q.push_back(new_entry(rob_pkg::STORE));
        repeat (40) stim_q.push_back(new_entry(int_opcode()));
        drive_batch();
        build_expected();
        wait_drain();
        if (!ready_low_seen) begin
            report_error("ins_ready_o never dropped");
        end
        close_test("test 2 integer stream");

        sb_base = 1;
        repeat (24) begin
            case ($unsigned($random(seed)) % 4)
                0:       e = new_entry(rob_pkg::JAL);
                1:       e = new_entry(rob_pkg::JALR);
                2:       e = new_entry(rob_pkg::BRANCH);
                default: e = new_entry(int_opcode());
            endcase
            stim_q.push_back(e);
        end
        drive_batch();
        build_expected();
        close_test("test 3 jumps and branches");

        sb_base = 3;
        repeat (16) begin
            stim_q.push_back(new_entry($random(seed) & 1 ? rob_pkg::STORE : int_opcode()));
        end
        drive_batch();
        build_expected();
        close_test("test 4 stores");

        // Mispredicted branch followed by a fresh stream after resume
        repeat (3) stim_q.push_back(new_entry(int_opcode()));
        e = new_entry(rob_pkg::BRANCH);
        e.mispredicted = 1'b1;
        stim_q.push_back(e);
        repeat (8) stim_q.push_back(new_entry(int_opcode()));
        drive_batch();
        build_expected();
        wait_drain();
        repeat (10) stim_q.push_back(new_entry(int_opcode()));
        drive_batch();
        build_expected();
        close_test("test 5 mispredict");

        repeat (2) stim_q.push_back(new_entry(int_opcode()));
        e = new_entry(rob_pkg::OP);
        e.except_raised = 1'b1;
        e.except_code   = 5'd2;
        e.rd_idx        = 5'd7;
        stim_q.push_back(e);
        repeat (6) stim_q.push_back(new_entry(int_opcode()));
        drive_batch();
        build_expected();
        close_test("test 6 exception");

        $display("tests run: 6, errors: %0d", err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/rob_pkg.sv
common/commit_pkg.sv
rtl/spill_cell.sv
rtl/rob_fifo.sv
commit_stage/commit_decoder.sv
commit_stage/commit_cu.sv
commit_stage/commit_stage.sv
rtl/commit_top.sv
dv/tb_clk_gen.sv
dv/tb_commit.sv

// File: Bender.yml
package:
  name: commit_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rob_pkg.sv
      - common/commit_pkg.sv
      - rtl/spill_cell.sv
      - rtl/rob_fifo.sv
      - commit_stage/commit_decoder.sv
      - commit_stage/commit_cu.sv
      - commit_stage/commit_stage.sv
      - rtl/commit_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_commit.sv
